// File: common/video_pkg.sv
// shared definitions for the test-pattern video core
// raster and square geometry, colour constants, bridge map,
// key bit positions and the pixel and bus types

package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // free-running raster counter, unsigned
    typedef logic [9:0] raster_t;

    // visible coordinate or square position, may go negative
    typedef logic signed [9:0] coord_t;

    // 8 bits each of red, green, blue
    typedef logic [23:0] rgb_t;

    // controller key bitmap, one bit per button
    typedef logic [15:0] key_map_t;

    // bridge address and data word
    typedef logic [31:0] bridge_word_t;

    // square either steered by the d-pad or sliding under the menu
    typedef enum logic {
        mode_steer,
        mode_slide
    } square_mode_t;

    //////////////////////////////////////////////////////////////////////
    // raster geometry, 400 x 512 = 204800 clocks per frame
    //////////////////////////////////////////////////////////////////////

    localparam raster_t h_total   = 10'd400;
    localparam raster_t h_bporch  = 10'd10;
    localparam raster_t h_active  = 10'd320;
    // hsync column, a few clocks after vsync
    localparam raster_t h_sync_x  = 10'd3;

    localparam raster_t v_total   = 10'd512;
    localparam raster_t v_bporch  = 10'd10;
    localparam raster_t v_active  = 10'd288;

    // square size and start position in visible coordinates
    localparam coord_t square_size   = 10'sd50;
    localparam coord_t square_init_x = 10'sd135;
    localparam coord_t square_init_y = 10'sd119;

    // colours
    localparam rgb_t rgb_black   = 24'h000000;
    localparam rgb_t rgb_white   = 24'hffffff;
    localparam rgb_t rgb_red     = 24'hff0000;
    localparam rgb_t rgb_green   = 24'h00ff00;
    localparam rgb_t rgb_blue    = 24'h0000ff;
    localparam rgb_t rgb_magenta = 24'hff00ff;

    // debug border register on the bridge
    localparam bridge_word_t border_reg_addr  = 32'h50000000;
    localparam logic         border_reset_val = 1'b1;

    // bit positions in the key bitmap
    localparam int key_up    = 0;
    localparam int key_down  = 1;
    localparam int key_left  = 2;
    localparam int key_right = 3;
    localparam int key_a     = 4;
    localparam int key_b     = 5;

endpackage

// File: files.f
+incdir+test
common/video_pkg.sv
video/video_timing.sv
video/pixel_compose.sv
hdl/square_mover.sv
hdl/bridge_regs.sv
hdl/video_core_top.sv
test/tb_video_core.sv

// File: hdl/bridge_regs.sv
// border control register on the host bridge
// bridge read mux, zero at unmapped addresses

`timescale 1ns/10ps

module bridge_regs import video_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset_n,
    input  bridge_word_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_word_t bridge_wr_data,
    output bridge_word_t bridge_rd_data,
    output logic         border_on
);

    logic border_sel;

    // single mapped register
    assign border_sel = (bridge_addr == border_reg_addr);

    // write strobe is one cycle, only bit 0 is kept
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            border_on <= border_reset_val;
        end else if (bridge_wr && border_sel) begin
            border_on <= bridge_wr_data[0];
        end
    end

    // reads are combinational, no wait states
    always_comb begin
        if (border_sel) begin
            bridge_rd_data = {31'b0, border_on};
        end else begin
            // unmapped space reads zero
            bridge_rd_data = '0;
        end
    end

endmodule

// File: hdl/square_mover.sv
// steer/slide mode FSM for the square
// square position registers, updated once per frame

`timescale 1ns/10ps

module square_mover import video_pkg::*; (
    input  logic     clk_74a,
    input  logic     reset_n,
    input  logic     frame_start,
    input  key_map_t keys,
    input  logic     menu_open,
    output coord_t   square_x,
    output coord_t   square_y
);

    square_mode_t mode;

    //////////////////////////////////////////////////////////////////////
    // position and mode, stepped at the frame start pixel
    //////////////////////////////////////////////////////////////////////

    // mode taken at one frame start drives the step at the next one
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            mode     <= mode_steer;
            square_x <= square_init_x;
            square_y <= square_init_y;
        end else if (frame_start) begin
            mode <= menu_open ? mode_slide : mode_steer;

            // up and down work in both modes
            // down checked last, so it wins when both are held
            if (keys[key_up] && (square_y > 10'sd0)) begin
                square_y <= square_y - 10'sd1;
            end
            if (keys[key_down] && (square_y < coord_t'(v_active) - square_size)) begin
                square_y <= square_y + 10'sd1;
            end

            case (mode)
                mode_steer: begin
                    // clamped to the active width
                    if (keys[key_left] && (square_x > 10'sd0)) begin
                        square_x <= square_x - 10'sd1;
                    end
                    if (keys[key_right] && (square_x < coord_t'(h_active) - square_size)) begin
                        square_x <= square_x + 10'sd1;
                    end
                end
                mode_slide: begin
                    // drift right, reappear fully off the left edge
                    if (square_x == coord_t'(h_active)) begin
                        square_x <= -square_size;
                    end else begin
                        square_x <= square_x + 10'sd1;
                    end
                end
                default: begin
                    square_x <= square_x;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // vertical clamp holds in both modes
    a_square_y_range: assert property (
        @(posedge clk_74a) disable iff (!reset_n)
        (square_y >= 10'sd0) && (square_y <= coord_t'(v_active) - square_size)
    );

endmodule

// File: hdl/video_core_top.sv
// top level of the test-pattern video core
// raster timing, square mover, bridge registers, pixel output

`timescale 1ns/10ps

module video_core_top import video_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset_n,

    // host bridge, bridge_rd kept for bus compatibility only
    input  bridge_word_t bridge_addr,
    input  logic         bridge_rd,
    input  logic         bridge_wr,
    input  bridge_word_t bridge_wr_data,
    output bridge_word_t bridge_rd_data,

    // controller and menu, already on clk_74a
    input  key_map_t     cont1_key,
    input  logic         osnotify_inmenu,

    // video to the scaler
    output rgb_t         video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs
);

    raster_t x_count;
    raster_t y_count;
    coord_t  visible_x;
    coord_t  visible_y;
    logic    frame_start;
    coord_t  square_x;
    coord_t  square_y;
    logic    border_on;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    video_timing u_timing (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .x_count     (x_count),
        .y_count     (y_count),
        .visible_x   (visible_x),
        .visible_y   (visible_y),
        .frame_start (frame_start)
    );

    square_mover u_square (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .keys        (cont1_key),
        .menu_open   (osnotify_inmenu),
        .square_x    (square_x),
        .square_y    (square_y)
    );

    bridge_regs u_bridge (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .border_on      (border_on)
    );

    pixel_compose u_compose (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .x_count     (x_count),
        .y_count     (y_count),
        .visible_x   (visible_x),
        .visible_y   (visible_y),
        .frame_start (frame_start),
        .square_x    (square_x),
        .square_y    (square_y),
        .border_on   (border_on),
        .keys        (cont1_key),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the video core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module tb_video_core -Mdir obj_dir -o sim_video
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_video > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "result: fail"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "no verdict found in sim.log"
exit 1

// File: test/tb_video_model.svh
// testbench model for the video core
// galois LFSR, expected pixel colour, typed compare tasks

`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////////////////////////

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

//////////////////////////////////////////////////////////////////////
// reference pixel
//////////////////////////////////////////////////////////////////////

// colour expected for raster position hx, hy
function automatic rgb_t expected_pixel(input int hx, input int hy, input int sx,
                                        input int sy, input logic border,
                                        input key_map_t keys);
    int   vx;
    int   vy;
    int   size;
    rgb_t colour;
    vx = hx - int'(h_bporch);
    vy = hy - int'(v_bporch);
    size = int'(square_size);
    colour = rgb_black;
    // porches stay black
    if (vx < 0 || vx >= int'(h_active) || vy < 0 || vy >= int'(v_active)) begin
        return rgb_black;
    end
    // border edges, columns before rows
    if (border) begin
        if (vx == 0) begin
            colour = rgb_white;
        end else if (vx == int'(h_active) - 1) begin
            colour = rgb_green;
        end else if (vy == 0) begin
            colour = rgb_red;
        end else if (vy == int'(v_active) - 1) begin
            colour = rgb_blue;
        end
    end
    // black frame around the square, fill one pixel in
    if (vx >= sx && vx < sx + size && vy >= sy && vy < sy + size) begin
        colour = rgb_black;
        if (vx > sx && vx < sx + size - 1 && vy > sy && vy < sy + size - 1) begin
            if (keys[key_a]) begin
                colour = rgb_magenta;
            end else if (keys[key_b]) begin
                colour = rgb_green;
            end else begin
                colour = rgb_white;
            end
        end
    end
    return colour;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_rgb(input rgb_t got, input rgb_t exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_word(input bridge_word_t got, input bridge_word_t exp,
                          input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

`endif

// File: test/tb_video_core.sv
// testbench for the test-pattern video core
// clock, reset, bridge and key stimulus, per-cycle output compare
// against the pixel model, timeout and verdict

`timescale 1ns/10ps

module tb_video_core import video_pkg::*; ();

    localparam int frame_cycles   = int'(h_total) * int'(v_total);
    localparam int timeout_cycles = 16 * frame_cycles;

    logic         clk_74a;
    logic         reset_n;
    bridge_word_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_word_t bridge_wr_data;
    bridge_word_t bridge_rd_data;
    key_map_t     cont1_key;
    logic         osnotify_inmenu;
    rgb_t         video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    // model state, raster position, square, mode and border
    int          model_x;
    int          model_y;
    int          model_sx;
    int          model_sy;
    logic        model_slide;
    logic        model_border;
    logic [31:0] lfsr_state;
    int          cycle_count;

    video_core_top UUT (
        .clk_74a         (clk_74a),
        .reset_n         (reset_n),
        .bridge_addr     (bridge_addr),
        .bridge_rd       (bridge_rd),
        .bridge_wr       (bridge_wr),
        .bridge_wr_data  (bridge_wr_data),
        .bridge_rd_data  (bridge_rd_data),
        .cont1_key       (cont1_key),
        .osnotify_inmenu (osnotify_inmenu),
        .video_rgb       (video_rgb),
        .video_de        (video_de),
        .video_hs        (video_hs),
        .video_vs        (video_vs)
    );

    `include "tb_video_model.svh"

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic key_map_t key_mask(input int pos);
        key_map_t mask;
        mask = '0;
        mask[pos] = 1'b1;
        return mask;
    endfunction

    // one square step, mode chosen at one frame start drives the next
    task automatic step_square();
        int old_x;
        int old_y;
        int max_x;
        int max_y;
        old_x = model_sx;
        old_y = model_sy;
        max_x = int'(h_active) - int'(square_size);
        max_y = int'(v_active) - int'(square_size);
        if (cont1_key[key_up] && old_y > 0) begin
            model_sy = old_y - 1;
        end
        if (cont1_key[key_down] && old_y < max_y) begin
            model_sy = old_y + 1;
        end
        if (!model_slide) begin
            if (cont1_key[key_left] && old_x > 0) begin
                model_sx = old_x - 1;
            end
            if (cont1_key[key_right] && old_x < max_x) begin
                model_sx = old_x + 1;
            end
        end else if (old_x == int'(h_active)) begin
            // wrap fully off the left edge
            model_sx = -int'(square_size);
        end else begin
            model_sx = old_x + 1;
        end
        model_slide = osnotify_inmenu;
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock and timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_74a = 1'b0;
        forever #5 clk_74a = ~clk_74a;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_74a);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    //////////////////////////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////////////////////////

    initial begin : compare_outputs
        rgb_t exp_rgb;
        logic exp_de;
        logic exp_hs;
        logic exp_vs;
        model_x = 0;
        model_y = 0;
        model_sx = int'(square_init_x);
        model_sy = int'(square_init_y);
        model_slide = 1'b0;
        model_border = border_reset_val;
        @(posedge reset_n);
        forever begin
            // inputs change 1 ns after the edge, so these are pre-edge values
            @(posedge clk_74a);
            exp_rgb = expected_pixel(model_x, model_y, model_sx, model_sy,
                                     model_border, cont1_key);
            exp_de = (model_x >= int'(h_bporch)) &&
                     (model_x < int'(h_bporch) + int'(h_active)) &&
                     (model_y >= int'(v_bporch)) &&
                     (model_y < int'(v_bporch) + int'(v_active));
            exp_hs = (model_x == int'(h_sync_x));
            exp_vs = (model_x == 0) && (model_y == 0);
            if (exp_vs) begin
                step_square();
            end
            if (bridge_wr && (bridge_addr == border_reg_addr)) begin
                model_border = bridge_wr_data[0];
            end
            // raster advance
            if (model_x == int'(h_total) - 1) begin
                model_x = 0;
                model_y = (model_y == int'(v_total) - 1) ? 0 : model_y + 1;
            end else begin
                model_x = model_x + 1;
            end
            @(negedge clk_74a);
            check_rgb(video_rgb, exp_rgb, "video_rgb");
            check_bit(video_de, exp_de, "video_de");
            check_bit(video_hs, exp_hs, "video_hs");
            check_bit(video_vs, exp_vs, "video_vs");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // tasks start and end 1 ns after a rising edge
    task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
        bridge_addr = addr;
        bridge_wr_data = data;
        bridge_wr = 1'b1;
        @(posedge clk_74a);
        #1 bridge_wr = 1'b0;
    endtask

    task automatic bridge_read(input bridge_word_t addr, input bridge_word_t exp);
        bridge_addr = addr;
        bridge_rd = 1'b1;
        @(negedge clk_74a);
        check_word(bridge_rd_data, exp, "bridge_rd_data");
        @(posedge clk_74a);
        #1 bridge_rd = 1'b0;
    endtask

    // returns in the cycle after the next vsync pulse
    task automatic wait_frame();
        do begin
            @(negedge clk_74a);
        end while (video_vs !== 1'b1);
        @(posedge clk_74a);
        #1;
    endtask

    task automatic random_word(output bridge_word_t word);
        word = '0;
        repeat (32) begin
            word = {word[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    initial begin : stimulus
        bridge_word_t addr;
        reset_n = 1'b0;
        bridge_addr = '0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        bridge_wr_data = '0;
        cont1_key = '0;
        osnotify_inmenu = 1'b0;
        lfsr_state = 32'h695a4371;

        // outputs held low while in reset
        repeat (2) begin
            @(negedge clk_74a);
            check_bit(video_de, 1'b0, "video_de");
            check_bit(video_hs, 1'b0, "video_hs");
            check_bit(video_vs, 1'b0, "video_vs");
            @(posedge clk_74a);
        end
        #1 reset_n = 1'b1;
        bridge_read(border_reg_addr, 32'h1);

        // full frame with border, no keys
        wait_frame();
        wait_frame();

        // border off, then unmapped space
        bridge_write(border_reg_addr, 32'h0);
        bridge_read(border_reg_addr, 32'h0);
        repeat (16) begin
            random_word(addr);
            if (addr == border_reg_addr) begin
                addr = addr ^ 32'h1;
            end
            bridge_read(addr, 32'h0);
        end
        wait_frame();

        // left and up for 3 frames
        cont1_key = key_mask(key_left) | key_mask(key_up);
        repeat (3) begin
            wait_frame();
        end
        check_word(bridge_word_t'(UUT.u_square.square_x), 32'd132, "square_x");
        check_word(bridge_word_t'(UUT.u_square.square_y), 32'd116, "square_y");

        // menu open for 3 frames, fill goes A then B
        osnotify_inmenu = 1'b1;
        cont1_key = key_mask(key_a) | key_mask(key_up);
        wait_frame();
        cont1_key = key_mask(key_b) | key_mask(key_up);
        wait_frame();
        cont1_key = key_mask(key_up);
        wait_frame();

        // menu closed, d-pad steers again
        osnotify_inmenu = 1'b0;
        cont1_key = key_mask(key_right);
        wait_frame();
        wait_frame();
        cont1_key = '0;
        check_word(bridge_word_t'(UUT.u_square.square_x), bridge_word_t'(model_sx),
                   "square_x");
        check_word(bridge_word_t'(UUT.u_square.square_y), bridge_word_t'(model_sy),
                   "square_y");
        wait_frame();

        repeat (10) @(posedge clk_74a);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: video/pixel_compose.sv
// pixel colour for the active window
// debug border, square with button-driven fill
// registered colour, data enable and sync outputs

`timescale 1ns/10ps

module pixel_compose import video_pkg::*; (
    input  logic     clk_74a,
    input  logic     reset_n,
    input  raster_t  x_count,
    input  raster_t  y_count,
    input  coord_t   visible_x,
    input  coord_t   visible_y,
    input  logic     frame_start,
    input  coord_t   square_x,
    input  coord_t   square_y,
    input  logic     border_on,
    input  key_map_t keys,
    output rgb_t     video_rgb,
    output logic     video_de,
    output logic     video_hs,
    output logic     video_vs
);

    logic in_window;
    logic in_square;
    logic in_inner;
    rgb_t pixel_rgb;

    // active window, 320 x 288 after the back porches
    assign in_window = (x_count >= h_bporch) && (x_count < h_bporch + h_active) &&
                       (y_count >= v_bporch) && (y_count < v_bporch + v_active);

    // outline of the square, 50 x 50
    assign in_square = (visible_x >= square_x) && (visible_x < square_x + square_size) &&
                       (visible_y >= square_y) && (visible_y < square_y + square_size);

    // fill, one pixel in from each edge
    assign in_inner = (visible_x >  square_x) &&
                      (visible_x <  square_x + square_size - 10'sd1) &&
                      (visible_y >  square_y) &&
                      (visible_y <  square_y + square_size - 10'sd1);

    //////////////////////////////////////////////////////////////////////
    // colour selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // porches and background are black
        pixel_rgb = rgb_black;
        if (in_window) begin
            // debug border, left and right edges win over top and bottom
            if (border_on) begin
                if (visible_x == 10'sd0) begin
                    pixel_rgb = rgb_white;
                end else if (visible_x == coord_t'(h_active - 10'd1)) begin
                    pixel_rgb = rgb_green;
                end else if (visible_y == 10'sd0) begin
                    pixel_rgb = rgb_red;
                end else if (visible_y == coord_t'(v_active - 10'd1)) begin
                    pixel_rgb = rgb_blue;
                end
            end
            // square drawn over the border
            if (in_square) begin
                pixel_rgb = rgb_black;
            end
            // buttons can change mid-frame, so the fill may tear
            if (in_inner) begin
                if (keys[key_a]) begin
                    pixel_rgb = rgb_magenta;
                end else if (keys[key_b]) begin
                    pixel_rgb = rgb_green;
                end else begin
                    pixel_rgb = rgb_white;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output registers, one clock behind the counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= rgb_black;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= pixel_rgb;
            video_de  <= in_window;
            // hs a few clocks after vs, never on the same cycle
            video_hs  <= (x_count == h_sync_x);
            video_vs  <= frame_start;
        end
    end

    // vsync falls in the porch, away from any active line
    a_de_not_at_vs: assert property (
        @(posedge clk_74a) disable iff (!reset_n)
        !($rose(video_de) && video_vs)
    );

endmodule

// File: video/video_timing.sv
// raster counter for the 400 x 512 frame
// visible coordinates relative to the back porches
// frame start strobe

`timescale 1ns/10ps

module video_timing import video_pkg::*; (
    input  logic    clk_74a,
    input  logic    reset_n,
    output raster_t x_count,
    output raster_t y_count,
    output coord_t  visible_x,
    output coord_t  visible_y,
    output logic    frame_start
);

    //////////////////////////////////////////////////////////////////////
    // raster counters
    //////////////////////////////////////////////////////////////////////

    // x runs every clock, y steps once per line
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            if (x_count == h_total - 10'd1) begin
                x_count <= '0;
                // end of line, move down or back to the top
                if (y_count == v_total - 10'd1) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 10'd1;
                end
            end else begin
                x_count <= x_count + 10'd1;
            end
        end
    end

    // visible coordinates, negative inside the back porch
    assign visible_x = coord_t'(x_count - h_bporch);
    assign visible_y = coord_t'(y_count - v_bporch);

    // top-left corner of the raster
    // sits in the porch, so the square can move here without tearing
    assign frame_start = (x_count == '0) && (y_count == '0);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // line length never overruns
    a_x_in_line: assert property (
        @(posedge clk_74a) disable iff (!reset_n)
        x_count < h_total
    );

endmodule
